// File: hw/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// ##############################
// Divider sizing
// ##############################

// Operand width in bits
`define DIV_WIDTH 16

// Wide enough to count DIV_WIDTH restoring steps
`define DIV_STEP_BITS 4

`endif

// File: hw/div_pkg.sv
`include "div_macros.svh"

package div_pkg;

    // ##############################
    // Data widths
    // ##############################

    // Dividend, divisor, quotient or remainder
    typedef logic [`DIV_WIDTH-1:0] operand_t;

    // Partial remainder, one extra bit for the sign of the trial difference
    typedef logic [`DIV_WIDTH:0] partial_t;

    // Restoring step count
    typedef logic [`DIV_STEP_BITS-1:0] step_t;

    // ##############################
    // Controller states
    // ##############################

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ITERATE = 2'd1,
        ST_DONE    = 2'd2
    } div_state_t;

endpackage

// File: hw/div_controller.sv
module div_controller (
    input  logic clk,
    input  logic reset,

    // Source side handshake
    input  logic src_valid,
    output logic src_ready,

    // Destination side handshake
    input  logic dst_ready,
    output logic dst_valid,

    // Step counter feedback
    input  logic last_step,

    // Enables for counter and datapath
    output logic load,
    output logic step
);

    div_pkg::div_state_t state;
    div_pkg::div_state_t state_next;

    // ##############################
    // State register
    // ##############################

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state <= div_pkg::ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // ##############################
    // Next state
    // ##############################

    always_comb
    begin
        state_next = state;
        case (state)
            div_pkg::ST_IDLE:
            begin
                // Operand pair taken this cycle
                if (src_valid)
                begin
                    state_next = div_pkg::ST_ITERATE;
                end
            end
            div_pkg::ST_ITERATE:
            begin
                // Final restoring step happens on this edge
                if (step && last_step)
                begin
                    state_next = div_pkg::ST_DONE;
                end
            end
            div_pkg::ST_DONE:
            begin
                // Hold result until the sink takes it
                if (dst_ready)
                begin
                    state_next = div_pkg::ST_IDLE;
                end
            end
            default:
            begin
                state_next = div_pkg::ST_IDLE;
            end
        endcase
    end

    // ##############################
    // Outputs decoded from state
    // ##############################

    always_comb
    begin
        src_ready = (state == div_pkg::ST_IDLE);
        dst_valid = (state == div_pkg::ST_DONE);

        // Load only on an accepted pair
        load = src_ready && src_valid;

        // One restoring step per iterate cycle
        step = (state == div_pkg::ST_ITERATE);
    end

endmodule

// File: hw/div_step_counter.sv
`include "div_macros.svh"

module div_step_counter (
    input  logic clk,
    input  logic reset,

    // Restart at the start of a division
    input  logic clear,

    // One restoring step done
    input  logic advance,

    // Count has reached the final step
    output logic last_step
);

    div_pkg::step_t count;

    // Index of the final restoring step
    localparam div_pkg::step_t LAST_COUNT = div_pkg::step_t'(`DIV_WIDTH - 1);

    // ##############################
    // Step count
    // ##############################

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            count <= '0;
        end
        else if (clear)
        begin
            count <= '0;
        end
        else if (advance)
        begin
            // Wraps back to zero after the last step
            count <= count + div_pkg::step_t'(1);
        end
    end

    // Final step decode
    assign last_step = (count == LAST_COUNT);

endmodule

// File: hw/div_datapath.sv
`include "div_macros.svh"

module div_datapath (
    input  logic clk,
    input  logic reset,

    // Controls from the sequencer
    input  logic load,
    input  logic step,

    // Operands, sampled on load
    input  div_pkg::operand_t dividend,
    input  div_pkg::operand_t divisor,

    // Result registers
    output div_pkg::operand_t quotient,
    output div_pkg::operand_t remainder
);

    // Divisor with zero extension to the partial width
    div_pkg::partial_t divisor_q;

    // Partial remainder, upper half of the shift pair
    div_pkg::partial_t rem_q;

    // Quotient, lower half of the shift pair, starts as the dividend
    div_pkg::operand_t quo_q;

    // Step logic
    div_pkg::partial_t rem_shift;
    div_pkg::operand_t quo_shift;
    div_pkg::partial_t trial_diff;
    logic              trial_neg;
    div_pkg::partial_t rem_next;
    div_pkg::operand_t quo_next;

    // ##############################
    // Shift and trial subtract
    // ##############################

    always_comb
    begin
        // Shift remainder and quotient left as one pair
        rem_shift = {rem_q[`DIV_WIDTH-1:0], quo_q[`DIV_WIDTH-1]};
        quo_shift = {quo_q[`DIV_WIDTH-2:0], 1'b0};

        // Try taking the divisor off the upper part
        trial_diff = rem_shift - divisor_q;

        // Sign bit of the difference decides the restore
        trial_neg = trial_diff[`DIV_WIDTH];
    end

    // ##############################
    // Restore or keep
    // ##############################

    always_comb
    begin
        if (trial_neg)
        begin
            // Divisor did not fit, restore and shift in a 0
            rem_next = rem_shift;
            quo_next = quo_shift;
        end
        else
        begin
            // Divisor fit, keep difference and shift in a 1
            rem_next = trial_diff;
            quo_next = quo_shift | div_pkg::operand_t'(1);
        end
    end

    // ##############################
    // Registers
    // ##############################

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            divisor_q <= '0;
            rem_q     <= '0;
            quo_q     <= '0;
        end
        else if (load)
        begin
            divisor_q <= {1'b0, divisor};
            rem_q     <= '0;
            quo_q     <= dividend;
        end
        else if (step)
        begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
    end

    // Results straight from the registers
    assign quotient  = quo_q;
    assign remainder = rem_q[`DIV_WIDTH-1:0];

endmodule

// File: hw/restoring_divider.sv
module restoring_divider (
    input  logic clk,
    input  logic reset,

    // Operand side
    input  div_pkg::operand_t dividend,
    input  div_pkg::operand_t divisor,
    input  logic              src_valid,
    output logic              src_ready,

    // Result side
    input  logic              dst_ready,
    output logic              dst_valid,
    output div_pkg::operand_t quotient,
    output div_pkg::operand_t remainder
);

    // Controller enables
    logic load;
    logic step;

    // Counter feedback
    logic last_step;

    // ##############################
    // Sequencer
    // ##############################

    div_controller ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .last_step (last_step),
        .load      (load),
        .step      (step)
    );

    // ##############################
    // Step counter
    // ##############################

    // Cleared on accept, counts each iterate cycle
    div_step_counter cnt0 (
        .clk       (clk),
        .reset     (reset),
        .clear     (load),
        .advance   (step),
        .last_step (last_step)
    );

    // ##############################
    // Shift-subtract datapath
    // ##############################

    div_datapath dp0 (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .step      (step),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

// File: testbench/tb_restoring_divider.sv
`include "div_macros.svh"

module tb_restoring_divider;

    localparam int CLK_PERIOD = 4;
    localparam int FIXED_ROWS = 7;
    localparam int ROWS = FIXED_ROWS + 20;

    // DUT ports
    logic              clk;
    logic              reset;
    div_pkg::operand_t dividend;
    div_pkg::operand_t divisor;
    logic              src_valid;
    logic              src_ready;
    logic              dst_ready;
    logic              dst_valid;
    div_pkg::operand_t quotient;
    div_pkg::operand_t remainder;

    // Stimulus table of operands, stall cycles and latency check flag
    div_pkg::operand_t row_dividend [ROWS];
    div_pkg::operand_t row_divisor [ROWS];
    int                row_stall [ROWS];
    logic              row_latency [ROWS];

    logic [31:0] rng_state;
    logic        table_filled;
    int          watchdog_cycles;
    int          error_count;
    int          pass_count;
    int          fail_count;

    restoring_divider dut0 (
        .clk       (clk),
        .reset     (reset),
        .dividend  (dividend),
        .divisor   (divisor),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ##############################
    // Helpers
    // ##############################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_operand(input div_pkg::operand_t actual,
                                 input div_pkg::operand_t expected, input string what);
        if (actual !== expected)
        begin
            $display("FAIL at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_latency(input int actual, input int expected, input string what);
        if (actual != expected)
        begin
            $display("FAIL at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic set_row(input int idx, input div_pkg::operand_t a,
                           input div_pkg::operand_t b, input int stall);
        row_dividend[idx] = a;
        row_divisor[idx]  = b;
        row_stall[idx]    = stall;
        row_latency[idx]  = 1'b1;
    endtask

    // ##############################
    // One division through the DUT
    // ##############################

    // Starts and ends 1 time unit after a rising edge
    task automatic run_row(input int idx);
        div_pkg::operand_t a;
        div_pkg::operand_t b;
        div_pkg::operand_t exp_q;
        div_pkg::operand_t exp_r;
        int                cycles;
        int                s;
        int                errors_before;
        a = row_dividend[idx];
        b = row_divisor[idx];
        errors_before = error_count;

        // Zero divisor gives all ones and the dividend back
        if (b == '0)
        begin
            exp_q = '1;
            exp_r = a;
        end
        else
        begin
            exp_q = a / b;
            exp_r = a % b;
        end

        dividend  = a;
        divisor   = b;
        src_valid = 1'b1;
        @(negedge clk);
        check_flag(src_ready, 1'b1, "src_ready before accept");
        check_flag(dst_valid, 1'b0, "dst_valid before accept");

        // Accept edge, then scramble the operand inputs
        @(posedge clk);
        #1;
        src_valid = 1'b0;
        rng_state = xorshift(rng_state);
        dividend  = div_pkg::operand_t'(rng_state);
        divisor   = div_pkg::operand_t'(rng_state >> 16);

        cycles = 0;
        while (!dst_valid)
        begin
            check_flag(src_ready, 1'b0, "src_ready while iterating");
            @(posedge clk);
            #1;
            cycles++;
        end
        check_flag(src_ready, 1'b0, "src_ready with result held");
        if (row_latency[idx])
        begin
            check_latency(cycles, `DIV_WIDTH, "cycles from accept to dst_valid");
        end
        check_operand(quotient, exp_q, "quotient");
        check_operand(remainder, exp_r, "remainder");

        // Back-pressure holds the result
        for (s = 0; s < row_stall[idx]; s++)
        begin
            @(posedge clk);
            #1;
            check_flag(dst_valid, 1'b1, "dst_valid during stall");
            check_flag(src_ready, 1'b0, "src_ready during stall");
            check_operand(quotient, exp_q, "quotient during stall");
            check_operand(remainder, exp_r, "remainder during stall");
        end

        dst_ready = 1'b1;
        @(posedge clk);
        #1;
        dst_ready = 1'b0;

        if (error_count == errors_before)
        begin
            pass_count++;
        end
        else
        begin
            fail_count++;
        end
        $display("Row %0d: %0d / %0d -> q %0d r %0d, stall %0d, %s", idx, a, b, exp_q, exp_r,
                 row_stall[idx], (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    // ##############################
    // Watchdog
    // ##############################

    initial
    begin
        wait (table_filled);
        #(watchdog_cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles: the divider stopped responding",
                 watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    // ##############################
    // Main sequence
    // ##############################

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b0;
        dividend     = '0;
        divisor      = '0;
        src_valid    = 1'b0;
        dst_ready    = 1'b0;
        rng_state    = 32'd13837;
        table_filled = 1'b0;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;

        set_row(0, div_pkg::operand_t'(100), div_pkg::operand_t'(7), 0);
        set_row(1, div_pkg::operand_t'(0), div_pkg::operand_t'(5), 3);
        set_row(2, div_pkg::operand_t'(65535), div_pkg::operand_t'(1), 0);
        set_row(3, div_pkg::operand_t'(65535), div_pkg::operand_t'(65535), 2);
        set_row(4, div_pkg::operand_t'(5), div_pkg::operand_t'(9), 0);
        set_row(5, div_pkg::operand_t'(1234), div_pkg::operand_t'(0), 5);
        set_row(6, div_pkg::operand_t'(40000), div_pkg::operand_t'(200), 1);

        // Random rows with mostly small divisors from the shift
        for (int i = FIXED_ROWS; i < ROWS; i++)
        begin
            rng_state = xorshift(rng_state);
            row_dividend[i] = div_pkg::operand_t'(rng_state);
            rng_state = xorshift(rng_state);
            row_divisor[i] = div_pkg::operand_t'(rng_state) >> rng_state[19:16];
            if ((i % 2 == 0) && (row_divisor[i] == '0))
            begin
                row_divisor[i] = div_pkg::operand_t'(1);
            end
            row_stall[i]   = int'(rng_state[22:20]);
            row_latency[i] = rng_state[23];
        end

        watchdog_cycles = 0;
        for (int i = 0; i < ROWS; i++)
        begin
            watchdog_cycles += `DIV_WIDTH + row_stall[i] + 8;
        end
        table_filled = 1'b1;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b1;
        @(negedge clk);
        check_flag(src_ready, 1'b1, "src_ready after reset");
        check_flag(dst_valid, 1'b0, "dst_valid after reset");
        @(posedge clk);
        #1;

        // Rows run back to back
        for (int i = 0; i < ROWS; i++)
        begin
            run_row(i);
        end
        @(negedge clk);
        check_flag(src_ready, 1'b1, "src_ready after last result");
        check_flag(dst_valid, 1'b0, "dst_valid after last result");

        $display("Rows passed %0d, rows failed %0d, check errors %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: restoring_divider.f
+incdir+hw
hw/div_pkg.sv
hw/div_controller.sv
hw/div_step_counter.sv
hw/div_datapath.sv
hw/restoring_divider.sv
testbench/tb_restoring_divider.sv

// File: run_sim.sh
#!/bin/sh
# Build the divider testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f restoring_divider.f \
    --top-module tb_restoring_divider -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1

grep -q "Test completed successfully" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass, see sim.log"; exit 1; }
